// ==== exec_alu.sv ====
// Execute stage arithmetic block

`timescale 1ns/1ps

module exec_alu
  import exec_cfg_pkg::*, exec_isa_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic [OP_W-1:0]      op_i,
  input  logic [XLEN-1:0]      reg_a_i,
  input  logic [XLEN-1:0]      reg_b_i,
  input  logic [XLEN-1:0]      operand_i,
  input  short_field_u         short_field_i,
  input  logic [REG_IDX_W-1:0] wr_idx_i,
  output logic [XLEN-1:0]      res_data_o,
  output logic [REG_IDX_W-1:0] res_idx_o,
  output logic                 res_wr_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_writes;
  logic [XLEN-1:0] inc_ext;

  // Increment value is always zero-extended
  assign inc_ext = {{(XLEN-BYTE_W){1'b0}}, short_field_i.inc.value};

  always_comb
  begin
    alu_result = '0;
    alu_writes = 1'b1;
    case (op_i)
      OP_ADD_L: alu_result = reg_a_i + reg_b_i;
      OP_SUB_L: alu_result = reg_a_i - reg_b_i;
      OP_AND:   alu_result = reg_a_i & reg_b_i;
      OP_OR:    alu_result = reg_a_i | reg_b_i;
      OP_XOR:   alu_result = reg_a_i ^ reg_b_i;
      OP_MUL_L: alu_result = reg_a_i * reg_b_i;
      // Shift amount is the full B register
      OP_ASHL:  alu_result = reg_a_i << reg_b_i;
      OP_LSHR:  alu_result = reg_a_i >> reg_b_i;
      OP_ASHR:  alu_result = $signed(reg_a_i) >>> reg_b_i;
      OP_NEG:   alu_result = -reg_b_i;
      OP_NOT:   alu_result = ~reg_b_i;
      OP_MOV:   alu_result = reg_b_i;
      OP_SEX_B: alu_result = {{(XLEN-BYTE_W){reg_b_i[BYTE_W-1]}}, reg_b_i[BYTE_W-1:0]};
      OP_SEX_S: alu_result = {{(XLEN-HALF_W){reg_b_i[HALF_W-1]}}, reg_b_i[HALF_W-1:0]};
      OP_ZEX_B: alu_result = {{(XLEN-BYTE_W){1'b0}}, reg_b_i[BYTE_W-1:0]};
      OP_ZEX_S: alu_result = {{(XLEN-HALF_W){1'b0}}, reg_b_i[HALF_W-1:0]};
      OP_LDI_L: alu_result = operand_i;
      OP_INC:   alu_result = reg_a_i + inc_ext;
      OP_DEC:   alu_result = reg_a_i - inc_ext;
      OP_NOP:
      begin
        alu_writes = 1'b0;
      end
      // cmp, branches, jumps and unknown opcodes leave the registers alone
      default:
      begin
        alu_writes = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      res_wr_o <= 1'b0;
    end
    else
    begin
      res_wr_o <= valid_i & alu_writes;
    end
  end

  // Result payload
  always_ff @(posedge clk_i)
  begin
    res_data_o <= alu_result;
    res_idx_o  <= wr_idx_i;
  end

endmodule

// ==== exec_branch_unit.sv ====
// Execute stage branch and retire control

`timescale 1ns/1ps

module exec_branch_unit
  import exec_cfg_pkg::*, exec_isa_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            valid_i,
  input  logic            flush_i,
  input  logic [OP_W-1:0] op_i,
  input  logic [XLEN-1:0] reg_a_i,
  input  logic [XLEN-1:0] reg_b_i,
  input  logic [XLEN-1:0] operand_i,
  input  logic [XLEN-1:0] pc_i,
  input  short_field_u    short_field_i,
  output logic            accept_o,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic [CC_W-1:0] flags_q;
  logic [CC_W-1:0] cmp_flags;
  logic [XLEN-1:0] a_sub_b;
  logic [XLEN-1:0] b_sub_a;
  logic            sign_diff;
  logic            accept_now;
  logic            cond_hold;
  logic [XLEN-1:0] disp_ext;
  logic [XLEN-1:0] pcrel_target;
  logic [XLEN-1:0] target_d;

  assign a_sub_b   = reg_a_i - reg_b_i;
  assign b_sub_a   = reg_b_i - reg_a_i;
  assign sign_diff = reg_a_i[XLEN-1] ^ reg_b_i[XLEN-1];

  // When signs differ the negative operand is the smaller one
  assign cmp_flags[CC_EQ]  = (reg_a_i == reg_b_i);
  assign cmp_flags[CC_LT]  = sign_diff ? reg_a_i[XLEN-1] : a_sub_b[XLEN-1];
  assign cmp_flags[CC_GT]  = sign_diff ? reg_b_i[XLEN-1] : b_sub_a[XLEN-1];
  assign cmp_flags[CC_LTU] = (reg_a_i < reg_b_i);
  assign cmp_flags[CC_GTU] = (reg_a_i > reg_b_i);

  // taken_o also acts as the shadow of a branch retired on the last edge
  assign accept_now = valid_i & ~flush_i & ~taken_o;

  always_comb
  begin
    case (op_i)
      OP_BEQ:  cond_hold = flags_q[CC_EQ];
      OP_BNE:  cond_hold = ~flags_q[CC_EQ];
      OP_BLT:  cond_hold = flags_q[CC_LT];
      OP_BGT:  cond_hold = flags_q[CC_GT];
      OP_BLTU: cond_hold = flags_q[CC_LTU];
      OP_BGTU: cond_hold = flags_q[CC_GTU];
      OP_BLE:  cond_hold = flags_q[CC_EQ] | flags_q[CC_LT];
      OP_BGE:  cond_hold = flags_q[CC_EQ] | flags_q[CC_GT];
      OP_BLEU: cond_hold = flags_q[CC_EQ] | flags_q[CC_LTU];
      OP_BGEU: cond_hold = flags_q[CC_EQ] | flags_q[CC_GTU];
      OP_JMP,
      OP_JMPA: cond_hold = 1'b1;
      default: cond_hold = 1'b0;
    endcase
  end

  // Half-word displacement relative to the next instruction
  assign disp_ext     = XLEN'(short_field_i.br_disp);
  assign pcrel_target = pc_i + XLEN'(2) + {disp_ext[XLEN-2:0], 1'b0};

  always_comb
  begin
    case (op_i)
      OP_JMP:  target_d = reg_a_i;
      OP_JMPA: target_d = operand_i;
      default: target_d = pcrel_target;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      accept_o <= 1'b0;
      taken_o  <= 1'b0;
      flags_q  <= '0;
    end
    else
    begin
      accept_o <= accept_now;
      taken_o  <= accept_now & cond_hold;
      if (accept_now && (op_i == OP_CMP))
      begin
        flags_q <= cmp_flags;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    target_o <= target_d;
  end

endmodule

// ==== exec_cfg_pkg.sv ====
// Execute stage size constants

package exec_cfg_pkg;

  // Data path width of the core
  localparam int XLEN = 32;

  // Sixteen general registers
  localparam int REG_IDX_W = 4;

  // Short field of the instruction word, shared by branches and inc/dec
  localparam int SHORT_FIELD_W = 10;

  // Sub-word widths used by the extension instructions
  localparam int BYTE_W = 8;
  localparam int HALF_W = 16;

endpackage

// ==== exec_isa_pkg.sv ====
// Execute stage instruction set encodings

package exec_isa_pkg;

  import exec_cfg_pkg::*;

  localparam int OP_W = 7;

  // Form 1 register instructions
  localparam logic [OP_W-1:0] OP_NOP    = 7'h00;
  localparam logic [OP_W-1:0] OP_LDI_L  = 7'h01;
  localparam logic [OP_W-1:0] OP_MOV    = 7'h02;
  localparam logic [OP_W-1:0] OP_ADD_L  = 7'h05;
  localparam logic [OP_W-1:0] OP_CMP    = 7'h0e;
  localparam logic [OP_W-1:0] OP_SEX_B  = 7'h10;
  localparam logic [OP_W-1:0] OP_SEX_S  = 7'h11;
  localparam logic [OP_W-1:0] OP_ZEX_B  = 7'h12;
  localparam logic [OP_W-1:0] OP_ZEX_S  = 7'h13;
  localparam logic [OP_W-1:0] OP_JMPA   = 7'h1a;
  localparam logic [OP_W-1:0] OP_JMP    = 7'h25;
  localparam logic [OP_W-1:0] OP_AND    = 7'h26;
  localparam logic [OP_W-1:0] OP_LSHR   = 7'h27;
  localparam logic [OP_W-1:0] OP_ASHL   = 7'h28;
  localparam logic [OP_W-1:0] OP_SUB_L  = 7'h29;
  localparam logic [OP_W-1:0] OP_NEG    = 7'h2a;
  localparam logic [OP_W-1:0] OP_OR     = 7'h2b;
  localparam logic [OP_W-1:0] OP_NOT    = 7'h2c;
  localparam logic [OP_W-1:0] OP_ASHR   = 7'h2d;
  localparam logic [OP_W-1:0] OP_XOR    = 7'h2e;
  localparam logic [OP_W-1:0] OP_MUL_L  = 7'h2f;

  // Form 2, immediate increment and decrement
  localparam logic [OP_W-1:0] OP_INC    = 7'h40;
  localparam logic [OP_W-1:0] OP_DEC    = 7'h41;

  // Form 3 conditional branches, in the order of the branch field
  localparam logic [OP_W-1:0] OP_BEQ    = 7'h60;
  localparam logic [OP_W-1:0] OP_BNE    = 7'h61;
  localparam logic [OP_W-1:0] OP_BLT    = 7'h62;
  localparam logic [OP_W-1:0] OP_BGT    = 7'h63;
  localparam logic [OP_W-1:0] OP_BLTU   = 7'h64;
  localparam logic [OP_W-1:0] OP_BGTU   = 7'h65;
  localparam logic [OP_W-1:0] OP_BGE    = 7'h66;
  localparam logic [OP_W-1:0] OP_BLE    = 7'h67;
  localparam logic [OP_W-1:0] OP_BGEU   = 7'h68;
  localparam logic [OP_W-1:0] OP_BLEU   = 7'h69;

  // Compare flag register layout
  localparam int CC_W   = 5;
  localparam int CC_EQ  = 0;
  localparam int CC_LT  = 1;
  localparam int CC_GT  = 2;
  localparam int CC_LTU = 3;
  localparam int CC_GTU = 4;

  // The short field is a signed half-word displacement for branches
  // and an 8-bit increment for inc/dec
  typedef union packed {
    logic signed [SHORT_FIELD_W-1:0] br_disp;
    struct packed {
      logic [SHORT_FIELD_W-BYTE_W-1:0] unused;
      logic [BYTE_W-1:0]               value;
    } inc;
  } short_field_u;

endpackage

// ==== exec_stage.f ====
exec_cfg_pkg.sv
exec_isa_pkg.sv
exec_alu.sv
exec_branch_unit.sv
exec_writeback_merge.sv
exec_stage.sv
exec_stage_props.sv
exec_stage_tb.sv

// ==== exec_stage.sv ====
// Execute stage top level

`timescale 1ns/1ps

module exec_stage
  import exec_cfg_pkg::*, exec_isa_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 flush_i,
  input  logic [OP_W-1:0]      op_i,
  input  logic [XLEN-1:0]      reg_a_i,
  input  logic [XLEN-1:0]      reg_b_i,
  input  logic [XLEN-1:0]      operand_i,
  input  short_field_u         short_field_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [REG_IDX_W-1:0] wr_idx_i,
  output logic                 wb_en_o,
  output logic [REG_IDX_W-1:0] wb_idx_o,
  output logic [XLEN-1:0]      wb_data_o,
  output logic                 branch_o,
  output logic [XLEN-1:0]      branch_target_o
);

  logic [XLEN-1:0]      res_data;
  logic [REG_IDX_W-1:0] res_idx;
  logic                 res_wr;
  logic                 accept;
  logic                 taken;
  logic [XLEN-1:0]      target;

  // Register results, independent of retire control
  exec_alu i_alu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .op_i          (op_i),
    .reg_a_i       (reg_a_i),
    .reg_b_i       (reg_b_i),
    .operand_i     (operand_i),
    .short_field_i (short_field_i),
    .wr_idx_i      (wr_idx_i),
    .res_data_o    (res_data),
    .res_idx_o     (res_idx),
    .res_wr_o      (res_wr)
  );

  exec_branch_unit i_branch_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .flush_i       (flush_i),
    .op_i          (op_i),
    .reg_a_i       (reg_a_i),
    .reg_b_i       (reg_b_i),
    .operand_i     (operand_i),
    .pc_i          (pc_i),
    .short_field_i (short_field_i),
    .accept_o      (accept),
    .taken_o       (taken),
    .target_o      (target)
  );

  exec_writeback_merge i_writeback_merge (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .res_data_i      (res_data),
    .res_idx_i       (res_idx),
    .res_wr_i        (res_wr),
    .accept_i        (accept),
    .taken_i         (taken),
    .target_i        (target),
    .wb_en_o         (wb_en_o),
    .wb_idx_o        (wb_idx_o),
    .wb_data_o       (wb_data_o),
    .branch_o        (branch_o),
    .branch_target_o (branch_target_o)
  );

endmodule

// ==== exec_stage_props.sv ====
// Execute stage output properties

`timescale 1ns/1ps

module exec_stage_props (
  input logic clk_i,
  input logic rst_i,
  input logic flush_i,
  input logic wb_en_i,
  input logic branch_i
);

  // No write-back while held in reset
  wb_low_in_reset: assert property (@(posedge clk_i) rst_i |-> !wb_en_i)
    else $error("wb_en_o high during reset");

  // The slot after a taken branch is always squashed
  no_back_to_back_branch: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_i |=> !branch_i)
    else $error("branch_o asserted on two consecutive cycles");

  // A flushed issue never reaches the write-back port
  no_wb_after_flush: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |-> ##2 !wb_en_i)
    else $error("wb_en_o high two cycles after flush_i");

endmodule

bind exec_stage exec_stage_props i_props (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .flush_i  (flush_i),
  .wb_en_i  (wb_en_o),
  .branch_i (branch_o)
);

// ==== exec_stage_tb.sv ====
// Execute stage testbench

`timescale 1ns/1ps

module exec_stage_tb
  import exec_cfg_pkg::*, exec_isa_pkg::*;
();

  localparam int PERIOD          = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int WATCHDOG_MARGIN = 20;
  localparam int MAX_ROWS        = 192;
  localparam logic [OP_W-1:0] OP_UNSUPPORTED = 7'h7f;
  localparam logic [OP_W-1:0] REG_OPS [17] = '{OP_ADD_L, OP_SUB_L, OP_AND, OP_OR, OP_XOR,
    OP_ASHL, OP_ASHR, OP_LSHR, OP_MUL_L, OP_NEG, OP_NOT, OP_MOV, OP_SEX_B, OP_SEX_S,
    OP_ZEX_B, OP_ZEX_S, OP_LDI_L};
  localparam logic [OP_W-1:0] BR_OPS [10] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU,
    OP_BGTU, OP_BLE, OP_BGE, OP_BLEU, OP_BGEU};
  // Operand pairs that set the signed and unsigned flags differently
  localparam logic [XLEN-1:0] CMP_A [4] = '{32'hffff_fffb, 32'd7, 32'd3, 32'd2};
  localparam logic [XLEN-1:0] CMP_B [4] = '{32'd3, 32'd7, 32'hffff_fffb, 32'd9};

  logic                 clk_i;
  logic                 rst_i;
  logic                 valid_i;
  logic                 flush_i;
  logic [OP_W-1:0]      op_i;
  logic [XLEN-1:0]      reg_a_i;
  logic [XLEN-1:0]      reg_b_i;
  logic [XLEN-1:0]      operand_i;
  short_field_u         short_field_i;
  logic [XLEN-1:0]      pc_i;
  logic [REG_IDX_W-1:0] wr_idx_i;
  logic                 wb_en_o;
  logic [REG_IDX_W-1:0] wb_idx_o;
  logic [XLEN-1:0]      wb_data_o;
  logic                 branch_o;
  logic [XLEN-1:0]      branch_target_o;

  // Stimulus and expected values, one row per issue cycle
  logic [OP_W-1:0]      tab_op    [MAX_ROWS];
  logic [XLEN-1:0]      tab_a     [MAX_ROWS];
  logic [XLEN-1:0]      tab_b     [MAX_ROWS];
  logic [XLEN-1:0]      tab_imm   [MAX_ROWS];
  logic [9:0]           tab_sf    [MAX_ROWS];
  logic [XLEN-1:0]      tab_pc    [MAX_ROWS];
  logic [REG_IDX_W-1:0] tab_idx   [MAX_ROWS];
  logic                 tab_valid [MAX_ROWS];
  logic                 tab_flush [MAX_ROWS];
  logic                 exp_wb    [MAX_ROWS];
  logic [XLEN-1:0]      exp_data  [MAX_ROWS];
  logic                 exp_br    [MAX_ROWS];
  logic [XLEN-1:0]      exp_tgt   [MAX_ROWS];

  // Reference retire state while the table is filled
  logic [CC_W-1:0] ref_flags;
  logic            ref_shadow;
  int              n_rows;
  int              error_count;
  int              check_count;
  integer          seed;
  logic            table_ready;

  exec_stage i_dut (.*);

  function automatic logic writes_reg(input logic [OP_W-1:0] op);
    case (op)
      OP_ADD_L, OP_SUB_L, OP_AND, OP_OR, OP_XOR, OP_ASHL, OP_ASHR, OP_LSHR, OP_MUL_L,
      OP_NEG, OP_NOT, OP_MOV, OP_SEX_B, OP_SEX_S, OP_ZEX_B, OP_ZEX_S, OP_LDI_L,
      OP_INC, OP_DEC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] expected_result(input logic [OP_W-1:0] op,
    input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
    input logic [9:0] sf);
    case (op)
      OP_ADD_L: return a + b;
      OP_SUB_L: return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_MUL_L: return a * b;
      OP_ASHL:  return a << b;
      OP_LSHR:  return a >> b;
      // Vacated upper bits take the sign
      OP_ASHR:  return (a >> b) | (a[31] ? ~(32'hffff_ffff >> b) : 32'h0);
      OP_NEG:   return 32'h0 - b;
      OP_NOT:   return ~b;
      OP_MOV:   return b;
      OP_SEX_B: return {{24{b[7]}}, b[7:0]};
      OP_SEX_S: return {{16{b[15]}}, b[15:0]};
      OP_ZEX_B: return {24'h0, b[7:0]};
      OP_ZEX_S: return {16'h0, b[15:0]};
      OP_LDI_L: return imm;
      OP_INC:   return a + {24'h0, sf[7:0]};
      OP_DEC:   return a - {24'h0, sf[7:0]};
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic condition_holds(input logic [OP_W-1:0] op);
    case (op)
      OP_BEQ:          return ref_flags[CC_EQ];
      OP_BNE:          return !ref_flags[CC_EQ];
      OP_BLT:          return ref_flags[CC_LT];
      OP_BGT:          return ref_flags[CC_GT];
      OP_BLTU:         return ref_flags[CC_LTU];
      OP_BGTU:         return ref_flags[CC_GTU];
      OP_BLE:          return ref_flags[CC_EQ] || ref_flags[CC_LT];
      OP_BGE:          return ref_flags[CC_EQ] || ref_flags[CC_GT];
      OP_BLEU:         return ref_flags[CC_EQ] || ref_flags[CC_LTU];
      OP_BGEU:         return ref_flags[CC_EQ] || ref_flags[CC_GTU];
      OP_JMP, OP_JMPA: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic add_row(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm, input logic [9:0] sf,
    input logic [XLEN-1:0] pc, input logic [REG_IDX_W-1:0] idx, input logic valid,
    input logic flush);
    logic accept;
    accept = valid && !flush && !ref_shadow;
    tab_op[n_rows]    = op;
    tab_a[n_rows]     = a;
    tab_b[n_rows]     = b;
    tab_imm[n_rows]   = imm;
    tab_sf[n_rows]    = sf;
    tab_pc[n_rows]    = pc;
    tab_idx[n_rows]   = idx;
    tab_valid[n_rows] = valid;
    tab_flush[n_rows] = flush;
    exp_wb[n_rows]    = accept && writes_reg(op);
    exp_data[n_rows]  = expected_result(op, a, b, imm, sf);
    exp_br[n_rows]    = accept && condition_holds(op);
    if (op == OP_JMP)
      exp_tgt[n_rows] = a;
    else if (op == OP_JMPA)
      exp_tgt[n_rows] = imm;
    else
      exp_tgt[n_rows] = pc + 32'd2 + {{21{sf[9]}}, sf, 1'b0};
    ref_shadow = exp_br[n_rows];
    if (accept && op == OP_CMP)
    begin
      ref_flags[CC_EQ]  = (a == b);
      ref_flags[CC_LT]  = ($signed(a) < $signed(b));
      ref_flags[CC_GT]  = ($signed(a) > $signed(b));
      ref_flags[CC_LTU] = (a < b);
      ref_flags[CC_GTU] = (a > b);
    end
    n_rows++;
  endtask

  task automatic build_table();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    // One fixed pass and two random passes over the register opcodes
    for (int p = 0; p < 3; p++)
    begin
      for (int i = 0; i < 17; i++)
      begin
        a   = (p == 0) ? 32'h8765_43f1 : $random(seed);
        b   = (p == 0) ? 32'h0001_8f9c : $random(seed);
        imm = $random(seed);
        if (REG_OPS[i] inside {OP_ASHL, OP_ASHR, OP_LSHR})
          b = b & 32'h1f;
        add_row(REG_OPS[i], a, b, imm, imm[21:12], '0, 4'(i), 1'b1, 1'b0);
      end
    end
    add_row(OP_INC, 32'h0000_00f0, '0, '0, 10'h025, '0, 4'h2, 1'b1, 1'b0);
    add_row(OP_INC, 32'hffff_fff0, '0, '0, 10'h3a5, '0, 4'h3, 1'b1, 1'b0);
    add_row(OP_DEC, 32'h0000_0010, '0, '0, 10'h0ff, '0, 4'h4, 1'b1, 1'b0);
    add_row(OP_DEC, 32'h0000_0100, '0, '0, 10'h2ff, '0, 4'h5, 1'b1, 1'b0);
    add_row(OP_LSHR, 32'hffff_0000, 32'd40, '0, '0, '0, 4'h6, 1'b1, 1'b0);
    add_row(OP_ASHR, 32'h8000_0000, 32'd40, '0, '0, '0, 4'h7, 1'b1, 1'b0);
    // Every branch after each compare, displacements from -512 upwards
    for (int p = 0; p < 4; p++)
    begin
      add_row(OP_CMP, CMP_A[p], CMP_B[p], '0, '0, '0, 4'h0, 1'b1, 1'b0);
      for (int i = 0; i < 10; i++)
      begin
        pc = 32'h0000_1000 + 32'(p * 64 + i * 4);
        add_row(BR_OPS[i], '0, '0, '0, 10'(i * 113 - 512), pc, 4'h0, 1'b1, 1'b0);
        add_row(OP_NOP, '0, '0, '0, '0, '0, 4'h0, 1'b1, 1'b0);
      end
    end
    // Squashed cmp in a jump shadow must not touch the flags
    add_row(OP_JMP, 32'h0000_4000, '0, '0, '0, '0, 4'h0, 1'b1, 1'b0);
    add_row(OP_CMP, 32'd5, 32'd5, '0, '0, '0, 4'h0, 1'b1, 1'b0);
    add_row(OP_BEQ, '0, '0, '0, 10'h010, 32'h2000, 4'h0, 1'b1, 1'b0);
    add_row(OP_ADD_L, 32'd1, 32'd2, '0, '0, '0, 4'h8, 1'b1, 1'b0);
    add_row(OP_JMPA, '0, '0, 32'h0000_8800, '0, '0, 4'h0, 1'b1, 1'b0);
    add_row(OP_ADD_L, 32'd3, 32'd4, '0, '0, '0, 4'h9, 1'b1, 1'b0);
    // A jump in the shadow of a taken jump never branches
    add_row(OP_JMP, 32'h0000_6000, '0, '0, '0, '0, 4'h0, 1'b1, 1'b0);
    add_row(OP_JMPA, '0, '0, 32'h0000_6600, '0, '0, 4'h0, 1'b1, 1'b0);
    // Flushed, idle and unsupported issues
    add_row(OP_ADD_L, 32'd1, 32'd1, '0, '0, '0, 4'ha, 1'b1, 1'b1);
    add_row(OP_MOV, '0, 32'h55, '0, '0, '0, 4'hb, 1'b0, 1'b0);
    add_row(OP_UNSUPPORTED, 32'd7, 32'd7, '0, '0, '0, 4'hc, 1'b1, 1'b0);
    add_row(OP_CMP, 32'd9, 32'd9, '0, '0, '0, 4'h0, 1'b1, 1'b1);
    add_row(OP_BEQ, '0, '0, '0, 10'h020, 32'h3000, 4'h0, 1'b1, 1'b0);
    add_row(OP_JMP, 32'h0000_5000, '0, '0, '0, '0, 4'h0, 1'b1, 1'b1);
    add_row(OP_ZEX_B, '0, 32'h1234_56ab, '0, '0, '0, 4'hd, 1'b1, 1'b0);
    add_row(OP_CMP, 32'd9, 32'd9, '0, '0, '0, 4'h0, 1'b1, 1'b0);
    add_row(OP_BEQ, '0, '0, '0, 10'h3f0, 32'h3100, 4'h0, 1'b1, 1'b0);
    // Idle tail drains the pipeline
    add_row(OP_NOP, '0, '0, '0, '0, '0, 4'h0, 1'b0, 1'b0);
    add_row(OP_NOP, '0, '0, '0, '0, '0, 4'h0, 1'b0, 1'b0);
  endtask

  task automatic drive_row(input int r);
    valid_i       <= tab_valid[r];
    flush_i       <= tab_flush[r];
    op_i          <= tab_op[r];
    reg_a_i       <= tab_a[r];
    reg_b_i       <= tab_b[r];
    operand_i     <= tab_imm[r];
    short_field_i <= tab_sf[r];
    pc_i          <= tab_pc[r];
    wr_idx_i      <= tab_idx[r];
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
    input logic [XLEN-1:0] want);
    check_count++;
    if (got !== want)
    begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, want);
      error_count++;
    end
  endtask

  task automatic check_row(input int r);
    check_value($sformatf("row %0d wb_en_o", r), 32'(wb_en_o), 32'(exp_wb[r]));
    if (exp_wb[r])
    begin
      check_value($sformatf("row %0d wb_idx_o", r), 32'(wb_idx_o), 32'(tab_idx[r]));
      check_value($sformatf("row %0d wb_data_o", r), wb_data_o, exp_data[r]);
    end
    check_value($sformatf("row %0d branch_o", r), 32'(branch_o), 32'(exp_br[r]));
    if (exp_br[r])
      check_value($sformatf("row %0d branch_target_o", r), branch_target_o, exp_tgt[r]);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    wait (table_ready);
    #((n_rows + RESET_CYCLES + WATCHDOG_MARGIN) * PERIOD);
    $display("Watchdog expired before all table rows were checked");
    $display("test failed");
    $finish;
  end

  initial
  begin
    rst_i         = 1'b1;
    valid_i       = 1'b0;
    flush_i       = 1'b0;
    op_i          = OP_NOP;
    reg_a_i       = '0;
    reg_b_i       = '0;
    operand_i     = '0;
    short_field_i = '0;
    pc_i          = '0;
    wr_idx_i      = '0;
    ref_flags     = '0;
    ref_shadow    = 1'b0;
    n_rows        = 0;
    error_count   = 0;
    check_count   = 0;
    seed          = 32'h7bc9;
    table_ready   = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    // Outputs of row k are stable in the low phase two edges after issue
    for (int k = 0; k < n_rows + 2; k++)
    begin
      @(posedge clk_i);
      if (k < n_rows)
        drive_row(k);
      @(negedge clk_i);
      if (k >= 2)
        check_row(k - 2);
    end
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== exec_writeback_merge.sv ====
// Write-back and branch output stage

`timescale 1ns/1ps

module exec_writeback_merge
  import exec_cfg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [XLEN-1:0]      res_data_i,
  input  logic [REG_IDX_W-1:0] res_idx_i,
  input  logic                 res_wr_i,
  input  logic                 accept_i,
  input  logic                 taken_i,
  input  logic [XLEN-1:0]      target_i,
  output logic                 wb_en_o,
  output logic [REG_IDX_W-1:0] wb_idx_o,
  output logic [XLEN-1:0]      wb_data_o,
  output logic                 branch_o,
  output logic [XLEN-1:0]      branch_target_o
);

  // A squashed instruction keeps its ALU request but never writes
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_en_o  <= 1'b0;
      branch_o <= 1'b0;
    end
    else
    begin
      wb_en_o  <= res_wr_i & accept_i;
      branch_o <= taken_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wb_idx_o        <= res_idx_i;
    wb_data_o       <= res_data_i;
    branch_target_o <= target_i;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
verilator --binary --timing --assert -sv --top-module exec_stage_tb \
  -f exec_stage.f -Mdir obj_dir -o exec_stage_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/exec_stage_sim > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1
